// ==== amp_consts.svh ====
`ifndef AMP_CONSTS_SVH
`define AMP_CONSTS_SVH

`define AMP_FRAME_BITS 16

// clk cycles per sclk half period
`define AMP_SCLK_DIV 2

// signature registers 40 to 44
`define AMP_REG_SIG0 6'h28
`define AMP_REG_SIG1 6'h29
`define AMP_REG_SIG2 6'h2A
`define AMP_REG_SIG3 6'h2B
`define AMP_REG_SIG4 6'h2C
`define AMP_REG_CHIPID 6'h3E
`define AMP_REG_NUMAMP 6'h3F

// expected ASCII signature
`define AMP_SIG0 8'h49
`define AMP_SIG1 8'h4E
`define AMP_SIG2 8'h54
`define AMP_SIG3 8'h41
`define AMP_SIG4 8'h4E

`define AMP_CMD_READ 2'b11

// chip id codes for kinds 1 to 3
`define AMP_CHIPID_K1 8'h02
`define AMP_CHIPID_K2 8'h01
`define AMP_CHIPID_K3 8'h04

// amplifier count codes for kinds 1 to 3
`define AMP_NUMAMP_K1 8'h10
`define AMP_NUMAMP_K2 8'h20
`define AMP_NUMAMP_K3 8'h40

`define AMP_MAX_TRIES 4

`endif

// ==== amp_pkg.sv ====
package amp_pkg;

    // one SPI word, seen as an outgoing command or an incoming reply
    typedef union packed {
        struct packed {
            logic [1:0] op;
            logic [5:0] addr;
            logic [7:0] arg;
        } cmd;
        struct packed {
            logic [7:0] status;
            logic [7:0] data;
        } reply;
    } amp_frame_u;

    typedef enum logic [7:0] {
        IDLE        = 8'h00,
        SEND_SIG0   = 8'h01,
        SEND_SIG1   = 8'h02,
        SEND_SIG2   = 8'h03,
        SEND_SIG3   = 8'h04,
        SEND_SIG4   = 8'h05,
        SEND_CHIPID = 8'h06,
        SEND_NUMAMP = 8'h07,
        FLUSH0      = 8'h08,
        FLUSH1      = 8'h09,
        WAIT        = 8'h10,
        RETRY       = 8'h11,
        JUDGE       = 8'h12,
        DONE        = 8'h13
    } amp_probe_state_e;

endpackage

// ==== amp_spi_master.sv ====
`timescale 1ns/100ps
`include "amp_consts.svh"

module amp_spi_master (
    input  logic                clk,
    input  logic                rst,
    input  logic                xfer_start,
    input  amp_pkg::amp_frame_u tx_word,
    output logic                xfer_done,
    output amp_pkg::amp_frame_u rx_word,
    output logic                cs,
    output logic                sclk,
    output logic                mosi,
    input  logic                miso
);

    localparam int CNT_W = $clog2(`AMP_SCLK_DIV + 1);
    localparam int BIT_W = $clog2(`AMP_FRAME_BITS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`AMP_SCLK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`AMP_FRAME_BITS - 1);

    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_SHIFT = 2'd1;
    localparam logic [1:0] PH_CSUP = 2'd2;
    localparam logic [1:0] PH_DONE = 2'd3;

    logic [1:0]                 phase;
    logic [CNT_W-1:0]           div_cnt;
    logic [BIT_W-1:0]           bit_cnt;
    logic [`AMP_FRAME_BITS-1:0] tx_shift;
    logic [`AMP_FRAME_BITS-1:0] rx_shift;
    logic                       half_end;

    assign half_end = (div_cnt == CNT_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= PH_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            cs <= 1'b1;
            sclk <= 1'b0;
            mosi <= 1'b0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (xfer_start) begin
                        phase <= PH_SHIFT;
                        cs <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        // first bit out together with cs
                        mosi <= tx_word.cmd.op[1];
                    end
                end
                PH_SHIFT: begin
                    if (half_end) begin
                        div_cnt <= '0;
                        sclk <= ~sclk;
                        // falling edge moves to the next bit
                        if (sclk) begin
                            if (bit_cnt == BIT_LAST) begin
                                phase <= PH_CSUP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                mosi <= tx_shift[`AMP_FRAME_BITS-2];
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                PH_CSUP: begin
                    cs <= 1'b1;
                    mosi <= 1'b0;
                    phase <= PH_DONE;
                end
                default: begin
                    xfer_done <= 1'b1;
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && xfer_start) begin
            tx_shift <= tx_word;
        end else if (phase == PH_SHIFT && half_end) begin
            // sample miso as sclk rises
            if (sclk) begin
                tx_shift <= {tx_shift[`AMP_FRAME_BITS-2:0], 1'b0};
            end else begin
                rx_shift <= {rx_shift[`AMP_FRAME_BITS-2:0], miso};
            end
        end
        if (phase == PH_DONE) begin
            rx_word <= rx_shift;
        end
    end

    assert property (@(posedge clk) disable iff (rst) (phase == PH_IDLE) |-> cs)
        else $error("cs low with no transfer running");

    assert property (@(posedge clk) disable iff (rst) (phase != PH_IDLE) |-> !xfer_start)
        else $error("xfer_start raised during a transfer");

endmodule

// ==== amp_id_probe.sv ====
`timescale 1ns/100ps
`include "amp_consts.svh"

module amp_id_probe (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    output logic                done,
    output logic                fail,
    output logic [1:0]          dev_kind,
    output logic                xfer_start,
    output amp_pkg::amp_frame_u tx_word,
    input  logic                xfer_done,
    input  amp_pkg::amp_frame_u rx_word
);

    localparam int TRY_W = $clog2(`AMP_MAX_TRIES + 1);
    localparam logic [TRY_W-1:0] TRY_MAX = TRY_W'(`AMP_MAX_TRIES);
    localparam logic [TRY_W-1:0] TRY_LAST = TRY_W'(`AMP_MAX_TRIES - 1);

    localparam logic [1:0] CHK_NONE = 2'd0;
    localparam logic [1:0] CHK_SIG = 2'd1;
    localparam logic [1:0] CHK_ID = 2'd2;
    localparam logic [1:0] CHK_CNT = 2'd3;

    amp_pkg::amp_probe_state_e state;
    amp_pkg::amp_probe_state_e ret_state;
    amp_pkg::amp_probe_state_e step_ret;
    logic                      step_send;
    logic [5:0]                step_addr;
    logic [1:0]                step_chk;
    logic [7:0]                step_exp;
    logic [1:0]                chk_mode;
    logic [7:0]                exp_byte;
    logic [TRY_W-1:0]          try_cnt;
    logic [1:0]                kind_id;
    logic [1:0]                kind_cnt;
    logic [1:0]                id_kind;
    logic [1:0]                cnt_kind;
    logic                      id_ok;
    logic                      cnt_ok;
    logic                      reply_ok;

    function automatic amp_pkg::amp_frame_u read_cmd(input logic [5:0] addr);
        amp_pkg::amp_frame_u frame;
        frame.cmd.op = `AMP_CMD_READ;
        frame.cmd.addr = addr;
        frame.cmd.arg = 8'h00;
        return frame;
    endfunction

    // each send step issues one read and names the reply due from two frames back
    always_comb begin
        step_send = 1'b1;
        step_addr = `AMP_REG_SIG0;
        step_chk = CHK_SIG;
        step_exp = 8'h00;
        step_ret = amp_pkg::IDLE;
        case (state)
            amp_pkg::SEND_SIG0: begin
                step_chk = CHK_NONE;
                step_ret = amp_pkg::SEND_SIG1;
            end
            amp_pkg::SEND_SIG1: begin
                step_addr = `AMP_REG_SIG1;
                step_chk = CHK_NONE;
                step_ret = amp_pkg::SEND_SIG2;
            end
            amp_pkg::SEND_SIG2: begin
                step_addr = `AMP_REG_SIG2;
                step_exp = `AMP_SIG0;
                step_ret = amp_pkg::SEND_SIG3;
            end
            amp_pkg::SEND_SIG3: begin
                step_addr = `AMP_REG_SIG3;
                step_exp = `AMP_SIG1;
                step_ret = amp_pkg::SEND_SIG4;
            end
            amp_pkg::SEND_SIG4: begin
                step_addr = `AMP_REG_SIG4;
                step_exp = `AMP_SIG2;
                step_ret = amp_pkg::SEND_CHIPID;
            end
            amp_pkg::SEND_CHIPID: begin
                step_addr = `AMP_REG_CHIPID;
                step_exp = `AMP_SIG3;
                step_ret = amp_pkg::SEND_NUMAMP;
            end
            amp_pkg::SEND_NUMAMP: begin
                step_addr = `AMP_REG_NUMAMP;
                step_exp = `AMP_SIG4;
                step_ret = amp_pkg::FLUSH0;
            end
            // dummy reads of reg 40 bring back id and count
            amp_pkg::FLUSH0: begin
                step_chk = CHK_ID;
                step_ret = amp_pkg::FLUSH1;
            end
            amp_pkg::FLUSH1: begin
                step_chk = CHK_CNT;
                step_ret = amp_pkg::JUDGE;
            end
            default: step_send = 1'b0;
        endcase
    end

    always_comb begin
        id_ok = 1'b1;
        id_kind = 2'd0;
        case (rx_word.reply.data)
            `AMP_CHIPID_K1: id_kind = 2'd1;
            `AMP_CHIPID_K2: id_kind = 2'd2;
            `AMP_CHIPID_K3: id_kind = 2'd3;
            default: id_ok = 1'b0;
        endcase
        cnt_ok = 1'b1;
        cnt_kind = 2'd0;
        case (rx_word.reply.data)
            `AMP_NUMAMP_K1: cnt_kind = 2'd1;
            `AMP_NUMAMP_K2: cnt_kind = 2'd2;
            `AMP_NUMAMP_K3: cnt_kind = 2'd3;
            default: cnt_ok = 1'b0;
        endcase
        case (chk_mode)
            CHK_SIG: reply_ok = (rx_word.reply.status == 8'h00) && (rx_word.reply.data == exp_byte);
            CHK_ID: reply_ok = (rx_word.reply.status == 8'h00) && id_ok;
            CHK_CNT: reply_ok = (rx_word.reply.status == 8'h00) && cnt_ok;
            default: reply_ok = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= amp_pkg::IDLE;
            ret_state <= amp_pkg::IDLE;
            chk_mode <= CHK_NONE;
            try_cnt <= '0;
            xfer_start <= 1'b0;
            done <= 1'b0;
            fail <= 1'b0;
            dev_kind <= 2'b00;
        end else begin
            xfer_start <= 1'b0;
            if (step_send) begin
                xfer_start <= 1'b1;
                chk_mode <= step_chk;
                ret_state <= step_ret;
                state <= amp_pkg::WAIT;
            end else begin
                case (state)
                    amp_pkg::IDLE: begin
                        if (start) begin
                            try_cnt <= '0;
                            state <= amp_pkg::SEND_SIG0;
                        end
                    end
                    amp_pkg::WAIT: begin
                        if (xfer_done) begin
                            state <= reply_ok ? ret_state : amp_pkg::RETRY;
                        end
                    end
                    amp_pkg::RETRY: begin
                        try_cnt <= try_cnt + 1'b1;
                        if (try_cnt == TRY_LAST) begin
                            done <= 1'b1;
                            fail <= 1'b1;
                            state <= amp_pkg::DONE;
                        end else begin
                            state <= amp_pkg::SEND_SIG0;
                        end
                    end
                    amp_pkg::JUDGE: begin
                        if (kind_id == kind_cnt) begin
                            done <= 1'b1;
                            dev_kind <= kind_id;
                            state <= amp_pkg::DONE;
                        end else begin
                            state <= amp_pkg::RETRY;
                        end
                    end
                    amp_pkg::DONE: begin
                        if (!start) begin
                            done <= 1'b0;
                            fail <= 1'b0;
                            dev_kind <= 2'b00;
                            state <= amp_pkg::IDLE;
                        end
                    end
                    default: state <= amp_pkg::IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step_send) begin
            tx_word <= read_cmd(step_addr);
            exp_byte <= step_exp;
        end
        if (state == amp_pkg::WAIT && xfer_done) begin
            if (chk_mode == CHK_ID) begin
                kind_id <= id_kind;
            end
            if (chk_mode == CHK_CNT) begin
                kind_cnt <= cnt_kind;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) (dev_kind != 2'b00) |-> (done && !fail))
        else $error("dev_kind set outside a good result, state %s", state.name());

    assert property (@(posedge clk) disable iff (rst) try_cnt <= TRY_MAX)
        else $error("try counter past limit, state %s", state.name());

endmodule

// ==== amp_frontend_top.sv ====
`timescale 1ns/100ps

module amp_frontend_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    output logic       done,
    output logic       fail,
    output logic [1:0] dev_kind,
    output logic       cs,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso
);

    logic                xfer_start;
    logic                xfer_done;
    amp_pkg::amp_frame_u tx_word;
    amp_pkg::amp_frame_u rx_word;

    amp_id_probe probe0 (
        .clk(clk),
        .rst(rst),
        .start(start),
        .done(done),
        .fail(fail),
        .dev_kind(dev_kind),
        .xfer_start(xfer_start),
        .tx_word(tx_word),
        .xfer_done(xfer_done),
        .rx_word(rx_word)
    );

    // chip pins
    amp_spi_master spi0 (
        .clk(clk),
        .rst(rst),
        .xfer_start(xfer_start),
        .tx_word(tx_word),
        .xfer_done(xfer_done),
        .rx_word(rx_word),
        .cs(cs),
        .sclk(sclk),
        .mosi(mosi),
        .miso(miso)
    );

endmodule

// ==== amp_chip_model.sv ====
`timescale 1ns/100ps
`include "amp_consts.svh"

module amp_chip_model (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    localparam int LOG_DEPTH = 64;

    logic [7:0]                 regs [0:63];
    amp_pkg::amp_frame_u        log_word [0:LOG_DEPTH-1];
    amp_pkg::amp_frame_u        pipe_new;
    amp_pkg::amp_frame_u        pipe_old;
    amp_pkg::amp_frame_u        cmd;
    amp_pkg::amp_frame_u        reply;
    logic [`AMP_FRAME_BITS-1:0] tx_bits;
    logic [`AMP_FRAME_BITS-1:0] rx_bits;
    int                         frame_count;
    int                         attempt_count;
    int                         corrupt_tries;

    task automatic load(input logic [39:0] sig, input logic [7:0] chip_id,
                        input logic [7:0] num_amp, input int corrupt);
        int i;
        for (i = 0; i < 64; i++) begin
            regs[6'(i)] = 8'h00;
        end
        regs[`AMP_REG_SIG0] = sig[39:32];
        regs[`AMP_REG_SIG1] = sig[31:24];
        regs[`AMP_REG_SIG2] = sig[23:16];
        regs[`AMP_REG_SIG3] = sig[15:8];
        regs[`AMP_REG_SIG4] = sig[7:0];
        regs[`AMP_REG_CHIPID] = chip_id;
        regs[`AMP_REG_NUMAMP] = num_amp;
        pipe_new = '0;
        pipe_old = '0;
        frame_count = 0;
        attempt_count = 0;
        corrupt_tries = corrupt;
    endtask

    initial begin
        miso = 1'b0;
        pipe_new = '0;
        pipe_old = '0;
        frame_count = 0;
        attempt_count = 0;
        corrupt_tries = 0;
        forever begin
            @(negedge cs);
            // reply to the command from two frames back
            tx_bits = pipe_old;
            miso = tx_bits[`AMP_FRAME_BITS-1];
            repeat (`AMP_FRAME_BITS) begin
                @(posedge sclk);
                rx_bits = {rx_bits[`AMP_FRAME_BITS-2:0], mosi};
                @(negedge sclk);
                tx_bits = {tx_bits[`AMP_FRAME_BITS-2:0], 1'b0};
                miso = tx_bits[`AMP_FRAME_BITS-1];
            end
            @(posedge cs);
            cmd = rx_bits;
            if (frame_count < LOG_DEPTH) begin
                log_word[6'(frame_count)] = cmd;
            end
            frame_count++;
            // every attempt reads register 41 exactly once
            if (cmd.cmd.addr == `AMP_REG_SIG1) begin
                attempt_count++;
            end
            reply = '0;
            if (cmd.cmd.op == `AMP_CMD_READ) begin
                reply.reply.data = regs[cmd.cmd.addr];
            end
            if (cmd.cmd.addr == `AMP_REG_SIG2 && attempt_count <= corrupt_tries) begin
                reply.reply.data = ~reply.reply.data;
            end
            pipe_old = pipe_new;
            pipe_new = reply;
        end
    end

endmodule

// ==== tb_amp_frontend.sv ====
`timescale 1ns/100ps
`include "amp_consts.svh"

module tb_amp_frontend;

    localparam int DONE_LIMIT = 6000;
    localparam int DROP_LIMIT = 20;
    localparam int HOLD_CYCLES = 10;

    logic       clk;
    logic       rst;
    logic       start;
    logic       done;
    logic       fail;
    logic [1:0] dev_kind;
    logic       cs;
    logic       sclk;
    logic       mosi;
    logic       miso;

    integer seed;
    int     err_count;
    int     test_errs;
    int     tests_run;
    int     tests_bad;

    // fields of the current golden line
    logic [8*24-1:0] t_name;
    logic [7:0]      s0, s1, s2, s3, s4;
    logic [7:0]      t_id;
    logic [7:0]      t_cnt;
    int              t_corrupt;
    int              t_fail;
    int              t_kind;
    // derived attempt shape
    int              t_len;
    int              t_bad_len;
    int              t_bad;
    int              t_tries;
    int              t_frames;

    amp_frontend_top dut0 (
        .clk(clk),
        .rst(rst),
        .start(start),
        .done(done),
        .fail(fail),
        .dev_kind(dev_kind),
        .cs(cs),
        .sclk(sclk),
        .mosi(mosi),
        .miso(miso)
    );

    amp_chip_model chip0 (
        .cs(cs),
        .sclk(sclk),
        .mosi(mosi),
        .miso(miso)
    );

    always #4 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %0s is %0h, expected %0h", $time, what, actual, expected);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %0s", $time, what);
        err_count++;
        test_errs++;
    endtask

    // frame of an attempt whose reply shows the first fault
    function automatic int attempt_len(input logic [39:0] sig, input logic [7:0] id);
        int len;
        if (sig[39:32] != `AMP_SIG0) begin
            len = 3;
        end else if (sig[31:24] != `AMP_SIG1) begin
            len = 4;
        end else if (sig[23:16] != `AMP_SIG2) begin
            len = 5;
        end else if (sig[15:8] != `AMP_SIG3) begin
            len = 6;
        end else if (sig[7:0] != `AMP_SIG4) begin
            len = 7;
        end else if (id != 8'h01 && id != 8'h02 && id != 8'h04) begin
            len = 8;
        end else begin
            // bad count, disagreement and success all need the ninth reply
            len = 9;
        end
        return len;
    endfunction

    function automatic logic [5:0] attempt_addr(input int idx);
        logic [5:0] addr;
        case (idx)
            5: addr = `AMP_REG_CHIPID;
            6: addr = `AMP_REG_NUMAMP;
            7, 8: addr = `AMP_REG_SIG0;
            default: addr = `AMP_REG_SIG0 + 6'(idx);
        endcase
        return addr;
    endfunction

    task automatic check_log();
        amp_pkg::amp_frame_u word;
        int a;
        int j;
        int pos;
        pos = 0;
        for (a = 0; a < t_tries; a++) begin
            for (j = 0; j < ((a < t_bad) ? t_bad_len : t_len); j++) begin
                word = chip0.log_word[6'(pos)];
                check_value(32'(word.cmd.op), 32'(`AMP_CMD_READ), "command op");
                check_value(32'(word.cmd.addr), 32'(attempt_addr(j)), "command address");
                check_value(32'(word.cmd.arg), 0, "command arg");
                pos++;
            end
        end
    endtask

    task automatic run_probe(input string label);
        int gap;
        int n;
        chip0.load({s0, s1, s2, s3, s4}, t_id, t_cnt, t_corrupt);
        gap = 2 + ($unsigned($random(seed)) % 16);
        repeat (gap) begin
            @(negedge clk);
            // idle pins: cs high, sclk low, mosi 0
            check_value(32'({cs, sclk, mosi}), 32'(3'b100),
                        $sformatf("%0s: cs, sclk, mosi between probes", label));
        end
        start = 1'b1;
        n = 0;
        while (done !== 1'b1 && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            report_timeout($sformatf("%0s: done never rose after start", label));
        end else begin
            check_value(32'(fail), t_fail, $sformatf("%0s: fail", label));
            check_value(32'(dev_kind), t_kind, $sformatf("%0s: dev_kind", label));
            check_value(chip0.frame_count, t_frames, $sformatf("%0s: frame count", label));
            check_value(chip0.attempt_count, t_tries, $sformatf("%0s: attempts", label));
            if (chip0.frame_count == t_frames) begin
                check_log();
            end
            // result holds while start stays high
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                check_value(32'({done, fail, dev_kind}), 32'({1'b1, t_fail[0], t_kind[1:0]}),
                            $sformatf("%0s: held result", label));
            end
        end
        start = 1'b0;
        n = 0;
        while (done !== 1'b0 && n < DROP_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b0) begin
            report_timeout($sformatf("%0s: done stayed high after start dropped", label));
        end else begin
            check_value(32'({fail, dev_kind}), 0, $sformatf("%0s: cleared result", label));
        end
    endtask

    task automatic run_test();
        test_errs = 0;
        t_len = attempt_len({s0, s1, s2, s3, s4}, t_id);
        // a corrupted byte 2 shows in the fifth reply
        t_bad_len = (t_len < 5) ? t_len : 5;
        t_bad = (t_corrupt < `AMP_MAX_TRIES) ? t_corrupt : `AMP_MAX_TRIES;
        t_tries = (t_fail != 0) ? `AMP_MAX_TRIES : t_bad + 1;
        t_frames = t_bad * t_bad_len + (t_tries - t_bad) * t_len;
        run_probe("first probe");
        run_probe("second probe");
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0s passed", t_name);
        end else begin
            tests_bad++;
            $display("test %0s had %0d errors", t_name, test_errs);
        end
    endtask

    initial begin
        int              fd;
        int              got;
        int              fields;
        logic [8*128-1:0] line;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        seed = 81207;
        err_count = 0;
        tests_run = 0;
        tests_bad = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("amp_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open amp_golden.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                fields = $sscanf(line, "%s %h %h %h %h %h %h %h %d %d %d", t_name,
                                 s0, s1, s2, s3, s4, t_id, t_cnt, t_corrupt, t_fail, t_kind);
                if (got > 0 && fields == 11) begin
                    run_test();
                end
            end
            $fclose(fd);
        end
        if (tests_run == 0) begin
            $display("no tests were read from the golden file");
            err_count++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_bad, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== amp_golden.txt ====
# name sig0 sig1 sig2 sig3 sig4 chip_id num_amp (hex) corrupt_tries fail kind (decimal)
# corrupt_tries counts leading attempts where the chip returns signature byte 2 inverted
kind2_ok       49 4E 54 41 4E 01 20 0 0 2
kind1_ok       49 4E 54 41 4E 02 10 0 0 1
kind3_ok       49 4E 54 41 4E 04 40 0 0 3
retry_then_ok  49 4E 54 41 4E 01 20 2 0 2
retry_limit    49 4E 54 41 4E 01 20 9 1 0
bad_sig4       49 4E 54 41 00 01 20 0 1 0
unknown_id     49 4E 54 41 4E 08 20 0 1 0
disagree       49 4E 54 41 4E 01 40 0 1 0
unknown_count  49 4E 54 41 4E 02 11 0 1 0

// ==== src.f ====
+incdir+.
amp_pkg.sv
amp_spi_master.sv
amp_id_probe.sv
amp_frontend_top.sv
amp_chip_model.sv
tb_amp_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_amp_frontend
RTL_TOP   ?= amp_frontend_top
RTL_SRCS  ?= amp_pkg.sv amp_spi_master.sv amp_id_probe.sv amp_frontend_top.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --timing --assert
FAIL_MSG  ?= >>> FAIL
PASS_MSG  ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
